// ==== Makefile ====
# Verilator flow for the gshare predictor.

TOP = gshareTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module gshareTop -f all.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== all.f ====
verilog/bpTypesPkg.sv
verilog/bpRegsPkg.sv
verilog/phtTable.sv
verilog/phtUpdateQueue.sv
verilog/gshareCore.sv
verilog/predictorRegs.sv
verilog/gshareTop.sv
testbench/gshareTb.sv

// ==== testbench/gshareTb.sv ====
// Testbench of the gshare branch predictor.
// Runs a table of fetch, resolve and Wishbone operations against a model of
// the counter table, the global history and the register block.
module gshareTb;
    timeunit 1ns;
    timeprecision 1ps;

    import bpTypesPkg::*;
    import bpRegsPkg::*;

    typedef enum logic [2:0] {
        OpFetch,
        OpResolve,
        OpDual,
        OpWrite,
        OpRead
    } OpKind;

    // Fetch rows reuse hist0 as the target index when aim is set.
    typedef struct packed {
        OpKind      op;
        logic       aim;
        AddrPath    pc0;
        AddrPath    pc1;
        HistoryPath hist0;
        HistoryPath hist1;
        logic [1:0] cond;
        logic [1:0] taken;
        logic [1:0] mis;
        WbAddrPath  adr;
        WbDataPath  data;
        logic       chk;
        WbDataPath  exp;
    } Row;

    logic          clk;
    logic          arstN;
    logic          fetchValid;
    AddrPath       fetchPc;
    logic          fetchIsCondBr;
    logic          resolve0Valid;
    AddrPath       resolve0Pc;
    HistoryPath    resolve0History;
    PhtCounterPath resolve0Counter;
    logic          resolve0Taken;
    logic          resolve0Mispred;
    logic          resolve0IsCondBr;
    logic          resolve1Valid;
    AddrPath       resolve1Pc;
    HistoryPath    resolve1History;
    PhtCounterPath resolve1Counter;
    logic          resolve1Taken;
    logic          resolve1Mispred;
    logic          resolve1IsCondBr;
    logic          resolveReady;
    logic          predValid;
    logic          predTaken;
    PhtCounterPath predCounter;
    HistoryPath    predHistory;
    logic          wbCyc;
    logic          wbStb;
    logic          wbWe;
    WbAddrPath     wbAdr;
    WbDataPath     wbDatW;
    WbDataPath     wbDatR;
    logic          wbAck;

    // Reference model state.
    PhtCounterPath pht [PHT_ENTRIES];
    HistoryPath    modelHist;
    logic          modelEnable;
    WbDataPath     branches;
    WbDataPath     mispreds;
    Row            rows [$];
    logic          tableReady = 1'b0;

    gshareTop i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare(input string name, input WbDataPath got, input WbDataPath want);
        if (got !== want) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
            $display(">>> FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic PhtIndexPath indexOf(AddrPath pc, HistoryPath hist);
        return pc[INSN_ADDR_LSB +: PHT_INDEX_WIDTH] ^ hist;
    endfunction

    // Random upper bits, with the index field picked so the pc lands on target.
    function automatic AddrPath pcFor(PhtIndexPath target, HistoryPath hist);
        AddrPath pc;
        pc = $urandom;
        pc[INSN_ADDR_LSB +: PHT_INDEX_WIDTH] = target ^ hist;
        return pc;
    endfunction

    function automatic PhtCounterPath trained(PhtCounterPath ctr, logic taken);
        int v;
        v = int'(ctr) + (taken ? 1 : -1);
        v = (v < 0) ? 0 : (v > int'(COUNTER_MAX)) ? int'(COUNTER_MAX) : v;
        return PhtCounterPath'(v);
    endfunction

    function automatic HistoryPath shiftIn(HistoryPath hist, logic dir);
        return {hist[PHT_INDEX_WIDTH-2:0], dir};
    endfunction

    // Queue is always drained when a row reads status.
    function automatic WbDataPath modelRead(WbAddrPath adr);
        case (adr)
            REG_CTRL:          return WbDataPath'(modelEnable);
            REG_STATUS:        return 32'h1;
            REG_BRANCH_COUNT:  return branches;
            REG_MISPRED_COUNT: return mispreds;
            REG_HISTORY:       return WbDataPath'(modelHist);
            default:           return '0;
        endcase
    endfunction

    function automatic Row fetchRow(logic cond, logic aim, PhtIndexPath target, logic chk,
                                    WbDataPath want);
        Row r;
        r = '0;
        r.op = OpFetch;
        r.pc0 = $urandom;
        r.cond = {1'b0, cond};
        r.aim = aim;
        r.hist0 = target;
        r.chk = chk;
        r.exp = want;
        return r;
    endfunction

    function automatic Row resolveRow(OpKind op, PhtIndexPath idx0, HistoryPath h0,
                                      PhtIndexPath idx1, HistoryPath h1, logic [1:0] cond,
                                      logic [1:0] taken, logic [1:0] mis);
        Row r;
        r = '0;
        r.op = op;
        r.pc0 = pcFor(idx0, h0);
        r.hist0 = h0;
        r.pc1 = pcFor(idx1, h1);
        r.hist1 = h1;
        r.cond = cond;
        r.taken = taken;
        r.mis = mis;
        return r;
    endfunction

    function automatic Row busRow(OpKind op, WbAddrPath adr, WbDataPath data, logic chk,
                                  WbDataPath want);
        Row r;
        r = '0;
        r.op = op;
        r.adr = adr;
        r.data = data;
        r.chk = chk;
        r.exp = want;
        return r;
    endfunction

    task automatic busCycle(input logic we, input WbAddrPath adr, input WbDataPath data,
                            output WbDataPath rd);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = data;
        @(posedge clk);
        #1;
        while (!wbAck) begin
            @(posedge clk);
            #1;
        end
        rd = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic waitSweep();
        WbDataPath status;
        status = '0;
        while (!status[STATUS_DONE_BIT]) begin
            busCycle(1'b0, REG_STATUS, '0, status);
        end
    endtask

    task automatic applyFetch(input Row r);
        AddrPath       pc;
        PhtCounterPath ctr;
        logic          expTaken;
        pc = r.aim ? pcFor(r.hist0, modelHist) : r.pc0;
        ctr = pht[indexOf(pc, modelHist)];
        expTaken = r.cond[0] && modelEnable && ctr[1];
        fetchValid = 1'b1;
        fetchPc = pc;
        fetchIsCondBr = r.cond[0];
        @(posedge clk);
        #1;
        fetchValid = 1'b0;
        compare("predValid", 32'(predValid), 32'h1);
        compare("predTaken", 32'(predTaken), 32'(expTaken));
        compare("predCounter", 32'(predCounter), 32'(ctr));
        compare("predHistory", 32'(predHistory), 32'(modelHist));
        if (r.chk)
            compare("predCounter", 32'(predCounter), r.exp);
        if (r.cond[0] && modelEnable)
            modelHist = shiftIn(modelHist, expTaken);
    endtask

    task automatic applyResolve(input Row r);
        logic          dual;
        PhtIndexPath   idx0;
        PhtIndexPath   idx1;
        PhtCounterPath ctr0;
        PhtCounterPath ctr1;
        dual = (r.op == OpDual);
        idx0 = indexOf(r.pc0, r.hist0);
        idx1 = indexOf(r.pc1, r.hist1);
        // Counters as fetch would have read them at predict time.
        ctr0 = pht[idx0];
        ctr1 = pht[idx1];
        compare("resolveReady", 32'(resolveReady), 32'h1);
        resolve0Valid = 1'b1;
        resolve0Pc = r.pc0;
        resolve0History = r.hist0;
        resolve0Counter = ctr0;
        resolve0Taken = r.taken[0];
        resolve0Mispred = r.mis[0];
        resolve0IsCondBr = r.cond[0];
        resolve1Valid = dual;
        resolve1Pc = r.pc1;
        resolve1History = r.hist1;
        resolve1Counter = ctr1;
        resolve1Taken = r.taken[1];
        resolve1Mispred = r.mis[1];
        resolve1IsCondBr = r.cond[1];
        @(posedge clk);
        #1;
        resolve0Valid = 1'b0;
        resolve1Valid = 1'b0;
        // Idle cycles let the update queue drain.
        repeat (2) @(posedge clk);
        #1;
        pht[idx0] = trained(ctr0, r.taken[0]);
        branches++;
        if (r.mis[0]) begin
            mispreds++;
            modelHist = r.cond[0] ? shiftIn(r.hist0, r.taken[0]) : r.hist0;
        end else if (dual) begin
            pht[idx1] = trained(ctr1, r.taken[1]);
            branches++;
            if (r.mis[1]) begin
                mispreds++;
                modelHist = r.cond[1] ? shiftIn(r.hist1, r.taken[1]) : r.hist1;
            end
        end
    endtask

    task automatic applyBus(input Row r);
        WbDataPath rd;
        busCycle(r.op == OpWrite, r.adr, r.data, rd);
        if (r.op == OpWrite) begin
            if (r.adr == REG_CTRL)
                modelEnable = r.data[CTRL_ENABLE_BIT];
            if (r.adr == REG_BRANCH_COUNT)
                branches = '0;
            if (r.adr == REG_MISPRED_COUNT)
                mispreds = '0;
        end else begin
            compare("wbDatR", rd, r.chk ? r.exp : modelRead(r.adr));
        end
    endtask

    task automatic buildTable();
        int a;
        // Back-to-back conditional fetches, then a non-conditional one.
        repeat (4) rows.push_back(fetchRow(1'b1, 1'b0, '0, 1'b1, 32'd2));
        rows.push_back(fetchRow(1'b0, 1'b0, '0, 1'b1, 32'd2));
        // Index 3c trained down past 0, then up past 3.
        repeat (3) rows.push_back(resolveRow(OpResolve, 8'h3c, 8'h5a, 8'h00, 8'h00,
                                             2'b01, 2'b00, 2'b00));
        rows.push_back(fetchRow(1'b1, 1'b1, 8'h3c, 1'b1, 32'd0));
        repeat (4) rows.push_back(resolveRow(OpResolve, 8'h3c, 8'h5a, 8'h00, 8'h00,
                                             2'b01, 2'b01, 2'b00));
        rows.push_back(fetchRow(1'b1, 1'b1, 8'h3c, 1'b1, 32'd3));
        // Slot 1 at 9e goes through the queue.
        rows.push_back(resolveRow(OpDual, 8'h71, 8'h12, 8'h9e, 8'he4, 2'b11, 2'b01, 2'b00));
        rows.push_back(busRow(OpRead, REG_STATUS, '0, 1'b1, 32'h1));
        rows.push_back(fetchRow(1'b1, 1'b1, 8'h71, 1'b1, 32'd3));
        rows.push_back(fetchRow(1'b1, 1'b1, 8'h9e, 1'b1, 32'd1));
        // Slot 0 mispredict, slot 1 at 0f is wrong path.
        rows.push_back(resolveRow(OpDual, 8'hc5, 8'ha6, 8'h0f, 8'h77, 2'b11, 2'b01, 2'b01));
        rows.push_back(busRow(OpRead, REG_HISTORY, '0, 1'b1, 32'h4d));
        rows.push_back(fetchRow(1'b1, 1'b1, 8'h0f, 1'b1, 32'd2));
        rows.push_back(resolveRow(OpResolve, 8'h20, 8'h33, 8'h00, 8'h00, 2'b00, 2'b00, 2'b01));
        rows.push_back(busRow(OpRead, REG_HISTORY, '0, 1'b1, 32'h33));
        // Prediction off, then on again.
        rows.push_back(busRow(OpWrite, REG_CTRL, 32'h0, 1'b0, '0));
        rows.push_back(busRow(OpRead, REG_CTRL, '0, 1'b1, 32'h0));
        repeat (2) rows.push_back(fetchRow(1'b1, 1'b0, '0, 1'b0, '0));
        rows.push_back(busRow(OpWrite, REG_CTRL, 32'h1, 1'b0, '0));
        rows.push_back(fetchRow(1'b1, 1'b0, '0, 1'b0, '0));
        rows.push_back(busRow(OpRead, REG_BRANCH_COUNT, '0, 1'b0, '0));
        rows.push_back(busRow(OpRead, REG_MISPRED_COUNT, '0, 1'b0, '0));
        rows.push_back(busRow(OpWrite, REG_BRANCH_COUNT, 32'hffff_ffff, 1'b0, '0));
        rows.push_back(busRow(OpRead, REG_BRANCH_COUNT, '0, 1'b1, 32'h0));
        rows.push_back(busRow(OpWrite, REG_MISPRED_COUNT, 32'h5, 1'b0, '0));
        rows.push_back(busRow(OpRead, REG_MISPRED_COUNT, '0, 1'b1, 32'h0));
        for (a = 5; a < 8; a++)
            rows.push_back(busRow(OpRead, WbAddrPath'(a), '0, 1'b1, 32'h0));
    endtask

    initial begin
        wait (tableReady);
        repeat (8 + PHT_ENTRIES + 20 * rows.size()) @(posedge clk);
        $display("Timeout: the test did not finish in the expected number of cycles");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hea3c_f272));
        arstN = 1'b0;
        fetchValid = 1'b0;
        fetchPc = '0;
        fetchIsCondBr = 1'b0;
        {resolve0Valid, resolve0Taken, resolve0Mispred, resolve0IsCondBr} = '0;
        {resolve1Valid, resolve1Taken, resolve1Mispred, resolve1IsCondBr} = '0;
        {resolve0Pc, resolve0History, resolve0Counter} = '0;
        {resolve1Pc, resolve1History, resolve1Counter} = '0;
        {wbCyc, wbStb, wbWe, wbAdr, wbDatW} = '0;
        foreach (pht[k])
            pht[k] = COUNTER_INIT;
        modelHist = '0;
        modelEnable = 1'b1;
        branches = '0;
        mispreds = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        compare("predValid", 32'(predValid), 32'h0);
        compare("wbAck", 32'(wbAck), 32'h0);
        compare("resolveReady", 32'(resolveReady), 32'h0);
        waitSweep();
        compare("resolveReady", 32'(resolveReady), 32'h1);
        foreach (rows[k]) begin
            case (rows[k].op)
                OpFetch:           applyFetch(rows[k]);
                OpResolve, OpDual: applyResolve(rows[k]);
                default:           applyBus(rows[k]);
            endcase
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog/bpRegsPkg.sv ====
// Register map and Wishbone widths of the predictor register block.
package bpRegsPkg;

    typedef logic [2:0] WbAddrPath;
    typedef logic [31:0] WbDataPath;

    // Word offsets on the bus.
    localparam WbAddrPath REG_CTRL = 3'd0;
    localparam WbAddrPath REG_STATUS = 3'd1;
    localparam WbAddrPath REG_BRANCH_COUNT = 3'd2;
    localparam WbAddrPath REG_MISPRED_COUNT = 3'd3;
    localparam WbAddrPath REG_HISTORY = 3'd4;

    // Field positions.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_LEVEL_LSB = 4;

endpackage

// ==== verilog/bpTypesPkg.sv ====
// Widths and type names of the gshare branch direction predictor.
// The table index is eight bits wide and the history covers all of it.
package bpTypesPkg;

    // Instruction addresses from fetch and execute.
    typedef logic [31:0] AddrPath;

    // Table geometry.
    localparam int PHT_INDEX_WIDTH = 8;
    localparam int PHT_ENTRIES = 1 << PHT_INDEX_WIDTH;
    typedef logic [PHT_INDEX_WIDTH-1:0] PhtIndexPath;

    // Global history, XORed over the whole index.
    typedef logic [PHT_INDEX_WIDTH-1:0] HistoryPath;

    // Word aligned instructions, so the index starts at address bit 2.
    localparam int INSN_ADDR_LSB = 2;

    // Two-bit saturating counters, reset to weakly taken.
    typedef logic [1:0] PhtCounterPath;
    localparam PhtCounterPath COUNTER_MAX = 2'd3;
    localparam PhtCounterPath COUNTER_INIT = 2'd2;

    // Writes waiting for the single table write port.
    localparam int QUEUE_DEPTH = 4;
    typedef logic [2:0] QueueLevelPath;

endpackage

// ==== verilog/gshareCore.sv ====
// Gshare direction predictor core.
// Hashes the fetch address with the global history, returns the counter
// one cycle later and folds resolved branches back into table and history.
module gshareCore (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      fetchValid,
    input  bpTypesPkg::AddrPath       fetchPc,
    input  logic                      fetchIsCondBr,
    input  logic                      resolve0Valid,
    input  bpTypesPkg::AddrPath       resolve0Pc,
    input  bpTypesPkg::HistoryPath    resolve0History,
    input  bpTypesPkg::PhtCounterPath resolve0Counter,
    input  logic                      resolve0Taken,
    input  logic                      resolve0Mispred,
    input  logic                      resolve0IsCondBr,
    input  logic                      resolve1Valid,
    input  bpTypesPkg::AddrPath       resolve1Pc,
    input  bpTypesPkg::HistoryPath    resolve1History,
    input  bpTypesPkg::PhtCounterPath resolve1Counter,
    input  logic                      resolve1Taken,
    input  logic                      resolve1Mispred,
    input  logic                      resolve1IsCondBr,
    output logic                      resolveReady,
    output logic                      predValid,
    output logic                      predTaken,
    output bpTypesPkg::PhtCounterPath predCounter,
    output bpTypesPkg::HistoryPath    predHistory,
    input  logic                      enable,
    output logic                      sweepDone,
    output bpTypesPkg::QueueLevelPath queueLevel,
    output bpTypesPkg::HistoryPath    history,
    output logic [1:0]                branchEvent,
    output logic [1:0]                mispredEvent
);
    import bpTypesPkg::*;

    function automatic PhtIndexPath hashIndex(AddrPath pc, HistoryPath hist);
        return pc[INSN_ADDR_LSB +: PHT_INDEX_WIDTH] ^ hist;
    endfunction

    function automatic PhtCounterPath nextCounter(PhtCounterPath cnt, logic taken);
        if (taken) begin
            return (cnt == COUNTER_MAX) ? cnt : cnt + 1'b1;
        end
        return (cnt == '0) ? cnt : cnt - 1'b1;
    endfunction

    // Only conditional branches carry a direction into the history.
    function automatic HistoryPath recoverHistory(HistoryPath hist, logic taken,
                                                  logic isCondBr);
        return isCondBr ? {hist[PHT_INDEX_WIDTH-2:0], taken} : hist;
    endfunction

    HistoryPath    historyReg;
    HistoryPath    nextHistory;
    logic          predIsCondBr;
    logic          take0;
    logic          take1;
    logic          tableWrite;
    PhtIndexPath   tableIndex;
    PhtCounterPath tableCounter;
    logic          queuePush;
    logic          queuePop;
    PhtIndexPath   headIndex;
    PhtCounterPath headCounter;
    logic          queueEmpty;
    logic          queueFull;

    assign resolveReady = sweepDone && !queueFull;
    assign take0 = resolve0Valid && resolveReady;
    // A mispredicted slot 0 puts slot 1 on the wrong path.
    assign take1 = resolve1Valid && resolveReady && !(take0 && resolve0Mispred);
    assign branchEvent = {take1, take0};
    assign mispredEvent = {take1 && resolve1Mispred, take0 && resolve0Mispred};

    assign predTaken = predValid && predIsCondBr && enable && predCounter[1];
    assign history = historyReg;

    // Speculative shift first, then recovery on top of it.
    // The result also indexes this cycle's read.
    always_comb begin
        nextHistory = historyReg;
        if (predValid && predIsCondBr && enable) begin
            nextHistory = {historyReg[PHT_INDEX_WIDTH-2:0], predTaken};
        end
        if (take0 && resolve0Mispred) begin
            nextHistory = recoverHistory(resolve0History, resolve0Taken, resolve0IsCondBr);
        end else if (take1 && resolve1Mispred) begin
            nextHistory = recoverHistory(resolve1History, resolve1Taken, resolve1IsCondBr);
        end
    end

    // Slot 0 wins the write port, slot 1 takes it or queues, the queue gets leftovers.
    always_comb begin
        tableWrite   = 1'b0;
        tableIndex   = headIndex;
        tableCounter = headCounter;
        queuePush    = 1'b0;
        queuePop     = 1'b0;
        if (take0) begin
            tableWrite   = 1'b1;
            tableIndex   = hashIndex(resolve0Pc, resolve0History);
            tableCounter = nextCounter(resolve0Counter, resolve0Taken);
            queuePush    = take1;
        end else if (take1) begin
            tableWrite   = 1'b1;
            tableIndex   = hashIndex(resolve1Pc, resolve1History);
            tableCounter = nextCounter(resolve1Counter, resolve1Taken);
        end else if (!queueEmpty) begin
            tableWrite = 1'b1;
            queuePop   = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            historyReg   <= '0;
            predValid    <= 1'b0;
            predIsCondBr <= 1'b0;
        end else begin
            historyReg   <= nextHistory;
            predValid    <= fetchValid && sweepDone;
            predIsCondBr <= fetchIsCondBr;
        end
    end

    // History the returned prediction was indexed with.
    always_ff @(posedge clk) begin
        predHistory <= nextHistory;
    end

    phtTable i_pht (
        .clk          (clk),
        .arstN        (arstN),
        .readIndex    (hashIndex(fetchPc, nextHistory)),
        .writeEnable  (tableWrite),
        .writeIndex   (tableIndex),
        .writeCounter (tableCounter),
        .readCounter  (predCounter),
        .sweepDone    (sweepDone)
    );

    // Slot 1 results that lost the write port.
    phtUpdateQueue i_queue (
        .clk         (clk),
        .arstN       (arstN),
        .push        (queuePush),
        .pushIndex   (hashIndex(resolve1Pc, resolve1History)),
        .pushCounter (nextCounter(resolve1Counter, resolve1Taken)),
        .pop         (queuePop),
        .headIndex   (headIndex),
        .headCounter (headCounter),
        .empty       (queueEmpty),
        .full        (queueFull),
        .level       (queueLevel)
    );

    // A resolve that meets a low resolveReady is held until it is taken.
    assert property (@(posedge clk) disable iff (!arstN)
        resolve0Valid && !resolveReady |=> resolve0Valid)
        else $error("resolve withdrawn while resolveReady was low");

endmodule

// ==== verilog/gshareTop.sv ====
// Gshare branch predictor top level.
// Connects the predictor core to its Wishbone register block.
module gshareTop (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      fetchValid,
    input  bpTypesPkg::AddrPath       fetchPc,
    input  logic                      fetchIsCondBr,
    input  logic                      resolve0Valid,
    input  bpTypesPkg::AddrPath       resolve0Pc,
    input  bpTypesPkg::HistoryPath    resolve0History,
    input  bpTypesPkg::PhtCounterPath resolve0Counter,
    input  logic                      resolve0Taken,
    input  logic                      resolve0Mispred,
    input  logic                      resolve0IsCondBr,
    input  logic                      resolve1Valid,
    input  bpTypesPkg::AddrPath       resolve1Pc,
    input  bpTypesPkg::HistoryPath    resolve1History,
    input  bpTypesPkg::PhtCounterPath resolve1Counter,
    input  logic                      resolve1Taken,
    input  logic                      resolve1Mispred,
    input  logic                      resolve1IsCondBr,
    output logic                      resolveReady,
    output logic                      predValid,
    output logic                      predTaken,
    output bpTypesPkg::PhtCounterPath predCounter,
    output bpTypesPkg::HistoryPath    predHistory,
    input  logic                      wbCyc,
    input  logic                      wbStb,
    input  logic                      wbWe,
    input  bpRegsPkg::WbAddrPath      wbAdr,
    input  bpRegsPkg::WbDataPath      wbDatW,
    output bpRegsPkg::WbDataPath      wbDatR,
    output logic                      wbAck
);

    // Control, status and statistics between core and registers.
    logic                      enable;
    logic                      sweepDone;
    bpTypesPkg::QueueLevelPath queueLevel;
    bpTypesPkg::HistoryPath    history;
    logic [1:0]                branchEvent;
    logic [1:0]                mispredEvent;

    gshareCore i_core (.*);

    predictorRegs i_regs (.*);

endmodule

// ==== verilog/phtTable.sv ====
// Pattern history table of 2-bit counters.
// One registered read and one write per cycle, and an init sweep after reset.
module phtTable (
    input  logic                      clk,
    input  logic                      arstN,
    input  bpTypesPkg::PhtIndexPath   readIndex,
    input  logic                      writeEnable,
    input  bpTypesPkg::PhtIndexPath   writeIndex,
    input  bpTypesPkg::PhtCounterPath writeCounter,
    output bpTypesPkg::PhtCounterPath readCounter,
    output logic                      sweepDone
);
    import bpTypesPkg::*;

    PhtCounterPath counters [PHT_ENTRIES];
    PhtIndexPath   sweepIndex;
    logic          memWrite;
    PhtIndexPath   memIndex;
    PhtCounterPath memValue;

    // The sweep owns the write port until every entry is set.
    always_comb begin
        memWrite = writeEnable;
        memIndex = writeIndex;
        memValue = writeCounter;
        if (!sweepDone) begin
            memWrite = 1'b1;
            memIndex = sweepIndex;
            memValue = COUNTER_INIT;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sweepIndex <= '0;
            sweepDone  <= 1'b0;
        end else if (!sweepDone) begin
            sweepIndex <= sweepIndex + 1'b1;
            sweepDone  <= (sweepIndex == PhtIndexPath'(PHT_ENTRIES - 1));
        end
    end

    // Read before write, so a same-address write returns the old counter.
    always_ff @(posedge clk) begin
        readCounter <= counters[readIndex];
        if (memWrite) begin
            counters[memIndex] <= memValue;
        end
    end

    // The core holds all updates back until the table is initialized.
    assert property (@(posedge clk) disable iff (!arstN) writeEnable |-> sweepDone)
        else $error("table update during init sweep");

endmodule

// ==== verilog/phtUpdateQueue.sv ====
// Small FIFO of counter writes waiting for the table write port.
// Filled by the second resolve slot, drained in cycles without a resolve.
module phtUpdateQueue (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      push,
    input  bpTypesPkg::PhtIndexPath   pushIndex,
    input  bpTypesPkg::PhtCounterPath pushCounter,
    input  logic                      pop,
    output bpTypesPkg::PhtIndexPath   headIndex,
    output bpTypesPkg::PhtCounterPath headCounter,
    output logic                      empty,
    output logic                      full,
    output bpTypesPkg::QueueLevelPath level
);
    import bpTypesPkg::*;

    PhtIndexPath   indexMem   [QUEUE_DEPTH];
    PhtCounterPath counterMem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0] headPtr;
    logic [$clog2(QUEUE_DEPTH)-1:0] tailPtr;

    assign empty = (level == '0);
    assign full = (level == QueueLevelPath'(QUEUE_DEPTH));
    assign headIndex = indexMem[headPtr];
    assign headCounter = counterMem[headPtr];

    // Pointers wrap on their own, the depth being a power of two.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            level   <= '0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            level <= level + QueueLevelPath'(push) - QueueLevelPath'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            indexMem[tailPtr]   <= pushIndex;
            counterMem[tailPtr] <= pushCounter;
        end
    end

    // resolveReady in the core must keep a free entry for every push.
    assert property (@(posedge clk) disable iff (!arstN) push |-> !full)
        else $error("update queue overflow");

    assert property (@(posedge clk) disable iff (!arstN) pop |-> !empty)
        else $error("update queue underflow");

endmodule

// ==== verilog/predictorRegs.sv ====
// Wishbone classic register block of the gshare predictor.
// Holds the enable bit and branch statistics, reads back status and history.
module predictorRegs (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      wbCyc,
    input  logic                      wbStb,
    input  logic                      wbWe,
    input  bpRegsPkg::WbAddrPath      wbAdr,
    input  bpRegsPkg::WbDataPath      wbDatW,
    input  logic                      sweepDone,
    input  bpTypesPkg::QueueLevelPath queueLevel,
    input  bpTypesPkg::HistoryPath    history,
    input  logic [1:0]                branchEvent,
    input  logic [1:0]                mispredEvent,
    output bpRegsPkg::WbDataPath      wbDatR,
    output logic                      wbAck,
    output logic                      enable
);
    import bpRegsPkg::*;

    typedef enum logic {
        RegsIdle,
        RegsAck
    } RegsState;

    RegsState  state;
    logic      request;
    logic      writeHit;
    WbDataPath readData;
    WbDataPath branchCount;
    WbDataPath mispredCount;

    assign request = wbCyc && wbStb && (state == RegsIdle);
    assign writeHit = request && wbWe;
    assign wbAck = (state == RegsAck);

    // One ack cycle per strobe, then back to idle.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= RegsIdle;
        end else begin
            case (state)
                RegsIdle: state <= request ? RegsAck : RegsIdle;
                default:  state <= RegsIdle;
            endcase
        end
    end

    // Writes land on the edge into the ack cycle.
    // A write of any value clears a count.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            enable       <= 1'b1;
            branchCount  <= '0;
            mispredCount <= '0;
        end else begin
            if (writeHit && wbAdr == REG_CTRL) begin
                enable <= wbDatW[CTRL_ENABLE_BIT];
            end
            if (writeHit && wbAdr == REG_BRANCH_COUNT) begin
                branchCount <= '0;
            end else begin
                branchCount <= branchCount + WbDataPath'(branchEvent[0])
                                           + WbDataPath'(branchEvent[1]);
            end
            if (writeHit && wbAdr == REG_MISPRED_COUNT) begin
                mispredCount <= '0;
            end else begin
                mispredCount <= mispredCount + WbDataPath'(mispredEvent[0])
                                             + WbDataPath'(mispredEvent[1]);
            end
        end
    end

    always_comb begin
        readData = '0;
        case (wbAdr)
            REG_CTRL:          readData[CTRL_ENABLE_BIT] = enable;
            REG_STATUS: begin
                readData[STATUS_DONE_BIT] = sweepDone;
                readData[STATUS_LEVEL_LSB +: $bits(queueLevel)] = queueLevel;
            end
            REG_BRANCH_COUNT:  readData = branchCount;
            REG_MISPRED_COUNT: readData = mispredCount;
            REG_HISTORY:       readData[$bits(history)-1:0] = history;
            default:           readData = '0;
        endcase
    end

    // Read data is captured with the request and held through the ack.
    always_ff @(posedge clk) begin
        if (request) begin
            wbDatR <= readData;
        end
    end

    // Every counted mispredict is also a counted branch.
    assert property (@(posedge clk) disable iff (!arstN) (mispredEvent & ~branchEvent) == '0)
        else $error("mispredict event without a branch event");

endmodule
